/* hdl/dcache_pkg.sv */
// Shared geometry, address layout and controller state for the data cache.
// Modules import this inside their bodies and use scoped names in port lists.
`default_nettype none

package dcache_pkg;

    localparam int ways     = 4;
    localparam int sets     = 8;
    localparam int s_offset = 5;
    localparam int s_index  = 3;
    localparam int s_tag    = 24;
    localparam int s_line   = 256;
    localparam int s_mask   = 32;

    typedef struct packed {
        logic [s_tag-1:0]    tag;
        logic [s_index-1:0]  index;
        logic [s_offset-1:0] offset;
    } dcache_fields_t;

    // one 32-bit address, as a byte address or split into cache fields
    typedef union packed {
        logic [31:0]    raw;
        dcache_fields_t fields;
    } dcache_addr_t;

    typedef enum logic [1:0] {
        check,
        respond,
        writeback,
        allocate
    } dcache_state_t;

    typedef logic [1:0] way_sel_t;

endpackage

`default_nettype wire

/* hdl/line_array.sv */
// Data store for one cache way: one 256-bit line per set.
// Reads are combinational; writes land per byte at the clock edge.
`default_nettype none

module line_array (
    input  wire logic                          clk,
    input  wire logic [dcache_pkg::s_mask-1:0]  write_en_i,
    input  wire logic [dcache_pkg::s_index-1:0] index_i,
    input  wire logic [dcache_pkg::s_line-1:0]  data_i,
    output logic      [dcache_pkg::s_line-1:0]  data_o
);
    import dcache_pkg::*;

    logic [s_line-1:0] lines [sets];

    assign data_o = lines[index_i];

    always_ff @(posedge clk) begin
        for (int b = 0; b < s_mask; b++) begin
            if (write_en_i[b]) begin
                lines[index_i][8*b +: 8] <= data_i[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_datapath.sv */
// Cache datapath: tag, valid, dirty and pseudo-LRU state per set, the four
// way data stores, hit detection, victim choice and the data/address muxes.
// Driven by the controller; all reads are combinational at the request index.
`default_nettype none

module dcache_datapath (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic [31:0]                   mem_address_i,
    input  wire logic [dcache_pkg::s_line-1:0] mem_wdata_i,
    input  wire logic [dcache_pkg::s_mask-1:0] mem_byte_enable_i,
    input  wire logic [dcache_pkg::s_line-1:0] pmem_rdata_i,
    input  wire logic                          mem_write_i,
    input  wire logic [dcache_pkg::ways-1:0]   tag_load_i,
    input  wire logic [dcache_pkg::ways-1:0]   valid_load_i,
    input  wire logic [dcache_pkg::ways-1:0]   dirty_load_i,
    input  wire logic                          dirty_value_i,
    input  wire logic                          fill_sel_i,
    input  wire dcache_pkg::way_sel_t          way_sel_i,
    input  wire logic                          wb_addr_sel_i,
    input  wire logic                          lru_update_i,
    output logic      [dcache_pkg::s_line-1:0] mem_rdata_o,
    output logic      [31:0]                   pmem_address_o,
    output logic      [dcache_pkg::s_line-1:0] pmem_wdata_o,
    output logic                               hit_o,
    output dcache_pkg::way_sel_t               hit_way_o,
    output dcache_pkg::way_sel_t               victim_way_o,
    output logic                               victim_dirty_o
);
    import dcache_pkg::*;

    dcache_addr_t      req_addr;
    dcache_addr_t      out_addr;
    logic [s_index-1:0] index;

    logic [ways-1:0]   valid_q [sets];
    logic [ways-1:0]   dirty_q [sets];
    logic [s_tag-1:0]  tag_q   [ways][sets];
    logic [2:0]        lru_q   [sets];

    logic [ways-1:0]   hit_vec;
    logic [s_line-1:0] line_in;
    logic [s_line-1:0] line_out [ways];
    logic [s_mask-1:0] way_we   [ways];
    logic [2:0]        lru;

    assign req_addr.raw = mem_address_i;
    assign index        = req_addr.fields.index;
    assign lru          = lru_q[index];

    // hit compare and way encode
    always_comb begin
        hit_way_o = '0;
        for (int i = 0; i < ways; i++) begin
            hit_vec[i] = valid_q[index][i] && (tag_q[i][index] == req_addr.fields.tag);
            if (hit_vec[i]) begin
                hit_way_o = way_sel_t'(i);
            end
        end
        hit_o = |hit_vec;
    end

    // lowest invalid way wins, else the tree pointer
    always_comb begin
        if (!lru[0]) begin
            victim_way_o = lru[2] ? way_sel_t'(2) : way_sel_t'(3);
        end else begin
            victim_way_o = lru[1] ? way_sel_t'(0) : way_sel_t'(1);
        end
        for (int i = ways - 1; i >= 0; i--) begin
            if (!valid_q[index][i]) begin
                victim_way_o = way_sel_t'(i);
            end
        end
        victim_dirty_o = valid_q[index][victim_way_o] && dirty_q[index][victim_way_o];
    end

    // fill writes the whole line, a cpu write only its enabled bytes
    always_comb begin
        line_in = fill_sel_i ? pmem_rdata_i : mem_wdata_i;
        for (int i = 0; i < ways; i++) begin
            way_we[i] = '0;
            if (way_sel_i == way_sel_t'(i) && dirty_load_i[i]) begin
                if (fill_sel_i) begin
                    way_we[i] = '1;
                end else if (mem_write_i) begin
                    way_we[i] = mem_byte_enable_i;
                end
            end
        end
    end

    for (genvar w = 0; w < ways; w++) begin : g_way
        line_array line_array_i (
            .clk        (clk),
            .write_en_i (way_we[w]),
            .index_i    (index),
            .data_i     (line_in),
            .data_o     (line_out[w])
        );
    end

    assign mem_rdata_o  = line_out[way_sel_i];
    assign pmem_wdata_o = line_out[way_sel_i];

    // writeback goes to the victim's own line, a fill to the request line
    always_comb begin
        out_addr.fields.tag    = wb_addr_sel_i ? tag_q[way_sel_i][index] : req_addr.fields.tag;
        out_addr.fields.index  = index;
        out_addr.fields.offset = '0;
        pmem_address_o         = out_addr.raw;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ways; i++) begin
            if (tag_load_i[i]) begin
                tag_q[i][index] <= req_addr.fields.tag;
            end
            if (dirty_load_i[i]) begin
                dirty_q[index][i] <= dirty_value_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            valid_q[index] <= valid_q[index] | valid_load_i;
            if (lru_update_i) begin
                // point the tree away from the way just used
                case (hit_way_o)
                    2'd0: lru_q[index][1:0] <= 2'b00;
                    2'd1: lru_q[index][1:0] <= 2'b10;
                    2'd2: {lru_q[index][2], lru_q[index][0]} <= 2'b01;
                    default: {lru_q[index][2], lru_q[index][0]} <= 2'b11;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_control.sv */
// Cache controller: answers hits, writes back dirty victims and fills lines.
// Drives the datapath's load strobes and mux selects from its state.
`default_nettype none

module dcache_control (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        mem_read_i,
    input  wire logic                        mem_write_i,
    input  wire logic                        pmem_resp_i,
    input  wire logic                        hit_i,
    input  wire dcache_pkg::way_sel_t        hit_way_i,
    input  wire dcache_pkg::way_sel_t        victim_way_i,
    input  wire logic                        victim_dirty_i,
    output logic                             mem_resp_o,
    output logic                             pmem_read_o,
    output logic                             pmem_write_o,
    output logic [dcache_pkg::ways-1:0]      tag_load_o,
    output logic [dcache_pkg::ways-1:0]      valid_load_o,
    output logic [dcache_pkg::ways-1:0]      dirty_load_o,
    output logic                             dirty_value_o,
    output logic                             fill_sel_o,
    output dcache_pkg::way_sel_t             way_sel_o,
    output logic                             wb_addr_sel_o,
    output logic                             lru_update_o
);
    import dcache_pkg::*;

    dcache_state_t   state_q;
    dcache_state_t   state_d;
    way_sel_t        victim_q;
    logic            skip_q;
    logic            request;
    logic [ways-1:0] hit_mask;
    logic [ways-1:0] victim_mask;

    // the request answered last cycle is still on the port
    assign request = (mem_read_i || mem_write_i) && !skip_q;

    always_comb begin
        hit_mask              = '0;
        hit_mask[hit_way_i]   = 1'b1;
        victim_mask           = '0;
        victim_mask[victim_q] = 1'b1;
    end

    always_comb begin
        state_d       = state_q;
        mem_resp_o    = 1'b0;
        pmem_read_o   = 1'b0;
        pmem_write_o  = 1'b0;
        tag_load_o    = '0;
        valid_load_o  = '0;
        dirty_load_o  = '0;
        dirty_value_o = 1'b0;
        fill_sel_o    = 1'b0;
        way_sel_o     = hit_way_i;
        wb_addr_sel_o = 1'b0;
        lru_update_o  = 1'b0;
        case (state_q)
            check: begin
                if (request) begin
                    if (hit_i) begin
                        state_d = respond;
                    end else if (victim_dirty_i) begin
                        state_d = writeback;
                    end else begin
                        state_d = allocate;
                    end
                end
            end
            respond: begin
                mem_resp_o   = 1'b1;
                lru_update_o = 1'b1;
                if (mem_write_i) begin
                    dirty_load_o  = hit_mask;
                    dirty_value_o = 1'b1;
                end
                state_d = check;
            end
            writeback: begin
                pmem_write_o  = 1'b1;
                way_sel_o     = victim_q;
                wb_addr_sel_o = 1'b1;
                if (pmem_resp_i) begin
                    state_d = allocate;
                end
            end
            allocate: begin
                pmem_read_o = 1'b1;
                way_sel_o   = victim_q;
                fill_sel_o  = 1'b1;
                if (pmem_resp_i) begin
                    // fresh line is clean
                    tag_load_o   = victim_mask;
                    valid_load_o = victim_mask;
                    dirty_load_o = victim_mask;
                    state_d      = check;
                end
            end
            default: state_d = check;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= check;
            skip_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            skip_q  <= (state_q == respond);
        end
    end

    // hold the victim while the fill rewrites the set
    always_ff @(posedge clk) begin
        if (state_q == check && request && !hit_i) begin
            victim_q <= victim_way_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache.sv */
// 4-way write-back data cache between a CPU line port and a memory line port.
// Requests on both ports are held levels answered by a one-cycle response.
`default_nettype none

module dcache (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          mem_read_i,
    input  wire logic                          mem_write_i,
    input  wire logic [31:0]                   mem_address_i,
    input  wire logic [dcache_pkg::s_line-1:0] mem_wdata_i,
    input  wire logic [dcache_pkg::s_mask-1:0] mem_byte_enable_i,
    output logic      [dcache_pkg::s_line-1:0] mem_rdata_o,
    output logic                               mem_resp_o,
    input  wire logic [dcache_pkg::s_line-1:0] pmem_rdata_i,
    input  wire logic                          pmem_resp_i,
    output logic                               pmem_read_o,
    output logic                               pmem_write_o,
    output logic      [31:0]                   pmem_address_o,
    output logic      [dcache_pkg::s_line-1:0] pmem_wdata_o
);
    import dcache_pkg::*;

    logic [ways-1:0] tag_load;
    logic [ways-1:0] valid_load;
    logic [ways-1:0] dirty_load;
    logic            dirty_value;
    logic            fill_sel;
    way_sel_t        way_sel;
    logic            wb_addr_sel;
    logic            lru_update;
    logic            hit;
    way_sel_t        hit_way;
    way_sel_t        victim_way;
    logic            victim_dirty;

    dcache_control dcache_control_i (
        .clk (clk), .reset_i (reset_i),
        .mem_read_i (mem_read_i), .mem_write_i (mem_write_i), .pmem_resp_i (pmem_resp_i),
        .hit_i (hit), .hit_way_i (hit_way),
        .victim_way_i (victim_way), .victim_dirty_i (victim_dirty),
        .mem_resp_o (mem_resp_o), .pmem_read_o (pmem_read_o), .pmem_write_o (pmem_write_o),
        .tag_load_o (tag_load), .valid_load_o (valid_load), .dirty_load_o (dirty_load),
        .dirty_value_o (dirty_value), .fill_sel_o (fill_sel), .way_sel_o (way_sel),
        .wb_addr_sel_o (wb_addr_sel), .lru_update_o (lru_update)
    );

    dcache_datapath dcache_datapath_i (
        .clk (clk), .reset_i (reset_i),
        .mem_address_i (mem_address_i), .mem_wdata_i (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i), .pmem_rdata_i (pmem_rdata_i),
        .mem_write_i (mem_write_i),
        .tag_load_i (tag_load), .valid_load_i (valid_load), .dirty_load_i (dirty_load),
        .dirty_value_i (dirty_value), .fill_sel_i (fill_sel), .way_sel_i (way_sel),
        .wb_addr_sel_i (wb_addr_sel), .lru_update_i (lru_update),
        .mem_rdata_o (mem_rdata_o), .pmem_address_o (pmem_address_o),
        .pmem_wdata_o (pmem_wdata_o),
        .hit_o (hit), .hit_way_o (hit_way),
        .victim_way_o (victim_way), .victim_dirty_o (victim_dirty)
    );

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// Testbench for the data cache: random CPU traffic against a golden memory and
// a mirror of tags, valid, dirty and pseudo-LRU state, with a line memory model.
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int clk_period  = 40;
    localparam int drive_delay = 5;
    localparam int n_lines     = 40;
    localparam int n_random    = 400;
    localparam int n_hits      = 24;
    localparam int n_tx        = 1 + n_random + n_hits + 17 + 12;
    localparam int watchdog_cycles = n_tx * 20 + 100;

    logic clk;
    logic reset_i;
    logic mem_read_i;
    logic mem_write_i;
    logic [31:0] mem_address_i;
    logic [s_line-1:0] mem_wdata_i;
    logic [s_mask-1:0] mem_byte_enable_i;
    logic [s_line-1:0] mem_rdata_o;
    logic mem_resp_o;
    logic [s_line-1:0] pmem_rdata_i;
    logic pmem_resp_i;
    logic pmem_read_o;
    logic pmem_write_o;
    logic [31:0] pmem_address_o;
    logic [s_line-1:0] pmem_wdata_o;

    // golden bytes, memory lines and the per-set cache mirror
    logic [7:0]        golden [logic [31:0]];
    logic [s_line-1:0] pmem_lines [logic [31:0]];
    logic [23:0]       model_tag [8][4];
    bit                model_valid [8][4];
    bit                model_dirty [8][4];
    logic [2:0]        model_lru [8];

    bit          ev_write [$];
    logic [31:0] ev_addr [$];
    logic [255:0] ev_data [$];
    int fills_done;
    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int tests_failed;
    int dirty_evictions;
    int clean_evictions;
    logic [31:0] pool [n_lines];

    dcache dcache_i (
        .clk (clk), .reset_i (reset_i),
        .mem_read_i (mem_read_i), .mem_write_i (mem_write_i),
        .mem_address_i (mem_address_i), .mem_wdata_i (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_rdata_o (mem_rdata_o), .mem_resp_o (mem_resp_o),
        .pmem_rdata_i (pmem_rdata_i), .pmem_resp_i (pmem_resp_i),
        .pmem_read_o (pmem_read_o), .pmem_write_o (pmem_write_o),
        .pmem_address_o (pmem_address_o), .pmem_wdata_o (pmem_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the cache did not finish the tests within %0d cycles",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [7:0] init_byte(input logic [31:0] a);
        logic [31:0] h;
        h = (a ^ 32'h5bd1e995) * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [255:0] golden_line(input logic [31:0] line_addr);
        logic [255:0] line;
        logic [31:0] a;
        for (int b = 0; b < 32; b++) begin
            a = line_addr + 32'(b);
            line[8*b +: 8] = golden.exists(a) ? golden[a] : init_byte(a);
        end
        return line;
    endfunction

    function automatic logic [255:0] memory_line(input logic [31:0] line_addr);
        logic [255:0] line;
        if (pmem_lines.exists(line_addr)) begin
            return pmem_lines[line_addr];
        end
        for (int b = 0; b < 32; b++) begin
            line[8*b +: 8] = init_byte(line_addr + 32'(b));
        end
        return line;
    endfunction

    function automatic logic [255:0] random_line();
        logic [255:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = $urandom();
        end
        return line;
    endfunction

    // lowest invalid way, else follow the tree
    function automatic int pick_victim(input logic [2:0] set);
        int victim;
        if (!model_lru[set][0]) begin
            victim = model_lru[set][2] ? 2 : 3;
        end else begin
            victim = model_lru[set][1] ? 0 : 1;
        end
        for (int w = 3; w >= 0; w--) begin
            if (!model_valid[set][w]) begin
                victim = w;
            end
        end
        return victim;
    endfunction

    function automatic void touch(input logic [2:0] set, input int way);
        if (way < 2) begin
            model_lru[set][0] = 1'b0;
            model_lru[set][1] = (way == 1);
        end else begin
            model_lru[set][0] = 1'b1;
            model_lru[set][2] = (way == 3);
        end
    endfunction

    task automatic check_value(input string what, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // one CPU transaction, checked against the mirror and the golden memory
    task automatic access(input bit write, input logic [31:0] addr,
                          input logic [255:0] wdata, input logic [31:0] be);
        logic [2:0] set;
        logic [31:0] line_addr;
        logic [31:0] victim_addr;
        logic [255:0] expect_line;
        logic [255:0] rdata;
        int way;
        int waited;
        int fills_start;
        int fills_seen;
        bit wb;
        bit resident;
        set = addr[7:5];
        line_addr = {addr[31:5], 5'b0};
        way = -1;
        wb = 1'b0;
        victim_addr = '0;
        for (int w = 0; w < 4; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == addr[31:8]) begin
                way = w;
            end
        end
        resident = (way >= 0);
        if (!resident) begin
            way = pick_victim(set);
            wb = model_valid[set][way] && model_dirty[set][way];
            victim_addr = {model_tag[set][way], set, 5'b0};
        end
        expect_line = golden_line(line_addr);
        ev_write.delete();
        ev_addr.delete();
        ev_data.delete();
        fills_start = fills_done;
        @(posedge clk);
        #drive_delay;
        mem_address_i = addr;
        mem_wdata_i = wdata;
        mem_byte_enable_i = be;
        mem_read_i = !write;
        mem_write_i = write;
        waited = 0;
        @(negedge clk);
        while (!mem_resp_o) begin
            waited++;
            @(negedge clk);
        end
        rdata = mem_rdata_o;
        fills_seen = fills_done - fills_start;
        @(posedge clk);
        #drive_delay;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        if (resident) begin
            check_value("hit latency in cycles", waited, 1);
            check_value("memory requests on a hit", ev_addr.size(), 0);
        end else begin
            check_value("fills before the response", fills_seen, 1);
            check_value("memory requests on a miss", ev_addr.size(), wb ? 2 : 1);
            if (ev_addr.size() == (wb ? 2 : 1)) begin
                if (wb) begin
                    check_value("writeback comes first", ev_write[0], 1);
                    check_value("writeback address", ev_addr[0], victim_addr);
                    check_value("writeback data", ev_data[0], golden_line(victim_addr));
                end
                check_value("fill is a read", ev_write[ev_write.size() - 1], 0);
                check_value("fill address", ev_addr[ev_addr.size() - 1], line_addr);
            end
            // counted from what the cache put on the memory port
            if (ev_write.size() > 0 && ev_write[0]) begin
                dirty_evictions++;
            end else if (model_valid[set][way]) begin
                clean_evictions++;
            end
            model_tag[set][way] = addr[31:8];
            model_valid[set][way] = 1'b1;
            model_dirty[set][way] = 1'b0;
        end
        if (!write) begin
            check_value("read data", rdata, expect_line);
        end
        touch(set, way);
        if (write) begin
            model_dirty[set][way] = 1'b1;
            for (int b = 0; b < 32; b++) begin
                if (be[b]) begin
                    golden[line_addr + 32'(b)] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    // answers one memory request at a time after 1 to 4 cycles
    initial begin
        int unsigned delay;
        pmem_resp_i = 1'b0;
        pmem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (pmem_read_o || pmem_write_o) begin
                ev_write.push_back(pmem_write_o);
                ev_addr.push_back(pmem_address_o);
                ev_data.push_back(pmem_wdata_o);
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                #drive_delay;
                if (pmem_write_o) begin
                    pmem_lines[pmem_address_o] = pmem_wdata_o;
                end else begin
                    pmem_rdata_i = memory_line(pmem_address_o);
                    fills_done++;
                end
                pmem_resp_i = 1'b1;
                @(posedge clk);
                #drive_delay;
                pmem_resp_i = 1'b0;
            end
        end
    end

    initial begin
        int set;
        int way;
        int dirty_start;
        int clean_start;
        logic [31:0] addr;
        void'($urandom(76));
        reset_i = 1'b1;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        mem_address_i = '0;
        mem_wdata_i = '0;
        mem_byte_enable_i = '0;
        for (int s = 0; s < 8; s++) begin
            model_lru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
        // five lines per set, so every set sees evictions
        for (int i = 0; i < n_lines; i++) begin
            pool[i] = {16'($urandom()), 8'(i / 8), 3'(i % 8), 5'b0};
        end
        repeat (2) @(posedge clk);
        #drive_delay;
        reset_i = 1'b0;

        @(negedge clk);
        check_value("idle outputs after reset", {mem_resp_o, pmem_read_o, pmem_write_o}, 0);
        access(1'b0, pool[0] | 32'h14, '0, '0);
        end_test("first access");

        repeat (n_random) begin
            addr = pool[$urandom_range(n_lines - 1, 0)] | 32'($urandom_range(31, 0));
            access(1'($urandom_range(1, 0)), addr, random_line(), $urandom());
        end
        end_test("random traffic");

        repeat (n_hits) begin
            set = $urandom_range(7, 0);
            way = $urandom_range(3, 0);
            // step on to a resident way of the set
            for (int k = 0; k < 3; k++) begin
                if (!model_valid[set][way]) begin
                    way = (way + 1) % 4;
                end
            end
            addr = {model_tag[set][way], 3'(set), 5'($urandom_range(31, 0))};
            access(1'($urandom_range(1, 0)), addr, random_line(), $urandom());
        end
        end_test("hit latency");

        for (int k = 0; k < 4; k++) begin
            access(1'b0, {24'hc0def0 + 24'(k), 3'd6, 5'd0}, '0, '0);
        end
        repeat (8) begin
            addr = {24'hc0def0 + 24'($urandom_range(3, 0)), 3'd6, 5'd0};
            access(1'($urandom_range(1, 0)), addr, random_line(), $urandom());
        end
        access(1'b0, {24'hc0def4, 3'd6, 5'd0}, '0, '0);
        for (int k = 0; k < 4; k++) begin
            access(1'b0, {24'hc0def0 + 24'(k), 3'd6, 5'd0}, '0, '0);
        end
        end_test("pseudo-LRU victim");

        dirty_start = dirty_evictions;
        clean_start = clean_evictions;
        for (int k = 0; k < 4; k++) begin
            access(1'b1, {24'hc0dee0 + 24'(k), 3'd3, 5'd0}, random_line(), $urandom());
        end
        for (int k = 4; k < 8; k++) begin
            access(1'b0, {24'hc0dee0 + 24'(k), 3'd3, 5'd0}, '0, '0);
        end
        for (int k = 0; k < 4; k++) begin
            access(1'b0, {24'hc0dee0 + 24'(k), 3'd3, 5'd0}, '0, '0);
        end
        check_value("dirty evictions seen", dirty_evictions > dirty_start, 1);
        check_value("clean evictions seen", clean_evictions > clean_start, 1);
        end_test("dirty and clean eviction");

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/dcache_pkg.sv
hdl/line_array.sv
hdl/dcache_datapath.sv
hdl/dcache_control.sv
hdl/dcache.sv
verification/dcache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= dcache_tb
RTL_TOP    ?= dcache
BUILD_DIR  ?= obj_dir
RTL_SRCS   ?= hdl/dcache_pkg.sv hdl/line_array.sv hdl/dcache_datapath.sv \
              hdl/dcache_control.sv hdl/dcache.sv
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_TEXT  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
